/* dcache_pkg.sv */
// Cache geometry, bus encodings, shared typedefs and the miss FSM state type
package dcache_pkg;

	typedef logic [31:0] addr_t;     // CPU byte address
	typedef logic [31:0] word_t;     // CPU data word
	typedef logic [63:0] beat_t;     // Bus beat, high half is the word with address bit 2 set
	typedef logic [7:0]  mask_t;     // Byte enables of one bus write
	typedef logic [21:0] tag_t;      // Address bits 31 to 10
	typedef logic [3:0]  index_t;    // Address bits 9 to 6
	typedef logic [2:0]  beat_idx_t; // Address bits 5 to 3
	typedef logic [3:0]  dev_id_t;   // Bus did and subdid fields
	typedef logic [3:0]  bus_len_t;  // Burst length in beats
	typedef logic [1:0]  bus_mode_t; // Bus request mode
	typedef logic [2:0]  credit_t;   // Outstanding request credits

	typedef enum logic [1:0] {
		MISS_IDLE,    // Serving hits and writes
		MISS_REQUEST, // Waiting for a credit to send the line read
		MISS_FILL     // Draining the returned beats into the line
	} miss_state_t;

	// Cache geometry
	localparam int NUM_LINES      = 16;
	localparam int BEATS_PER_LINE = 8;
	localparam int FILL_DEPTH     = 8;

	localparam credit_t INITIAL_CREDITS = 3'd4; // Credits granted by the bus at reset

	// Bus request modes
	localparam bus_mode_t MODE_READ  = 2'd1;
	localparam bus_mode_t MODE_WRITE = 2'd2;

	// Ids that route returned data back to this cache
	localparam dev_id_t DID_CPU       = 4'd1;
	localparam dev_id_t SUBDID_DCACHE = 4'd2;

	// Burst lengths
	localparam bus_len_t LINE_READ_LEN  = 4'd8;
	localparam bus_len_t WORD_WRITE_LEN = 4'd1;

endpackage

/* dcache_ifs.sv */
// Core to issuer request interface and fill buffer to core beat interface
`timescale 1ns/1ps

interface bus_req_if import dcache_pkg::*; ();
	logic  req;       // One-cycle request strobe
	logic  is_write;  // Write when set, line read otherwise
	addr_t addr;
	word_t wdata;
	logic  credit_ok; // At least one credit left

	modport core (
		output req, is_write, addr, wdata,
		input  credit_ok
	);

	modport issuer (
		input  req, is_write, addr, wdata,
		output credit_ok
	);
endinterface

interface fill_if import dcache_pkg::*; ();
	logic  beat_valid; // Buffer not empty
	beat_t beat_data;  // Head entry
	logic  pop;
	logic  clear;      // Empties the buffer at the start of a miss

	modport buffer (
		output beat_valid, beat_data,
		input  pop, clear
	);

	modport core (
		input  beat_valid, beat_data,
		output pop, clear
	);
endinterface

/* bus_req_issuer.sv */
// Bus request formatter and outbound credit counter
`timescale 1ns/1ps

module bus_req_issuer import dcache_pkg::*; (
	input  logic      clk,
	input  logic      rst_b,
	bus_req_if.issuer bus,
	output logic      out_valid,
	output bus_mode_t out_mode,
	output dev_id_t   out_did,
	output dev_id_t   out_subdid,
	output addr_t     out_addr,
	output bus_len_t  out_len,
	output beat_t     out_data,
	output mask_t     out_mask,
	input  logic      out_credit
);

	credit_t credits;

	assign bus.credit_ok = (credits != '0);
	assign out_valid = bus.req; // Every core strobe is exactly one bus cycle

	always_comb begin
		out_mode = '0;
		out_did = '0;
		out_subdid = '0;
		out_addr = '0;
		out_len = '0;
		out_data = '0;
		out_mask = '0;
		if (bus.req) begin
			out_did = DID_CPU;
			out_subdid = SUBDID_DCACHE;
			if (bus.is_write) begin
				out_mode = MODE_WRITE;
				out_addr = {bus.addr[31:3], 3'b000};
				out_len = WORD_WRITE_LEN;
				out_data = {bus.wdata, bus.wdata};  // Mask picks the half that counts
				out_mask = bus.addr[2] ? 8'hF0 : 8'h0F;
			end else begin
				out_mode = MODE_READ;
				out_addr = {bus.addr[31:6], 6'b000000}; // Whole line from its first beat
				out_len = LINE_READ_LEN;
			end
		end
	end

	// A returned credit and an issued request can land in the same cycle
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits <= INITIAL_CREDITS;
		end else begin
			credits <= credits + credit_t'(out_credit) - credit_t'(out_valid);
		end
	end

	// The core must only strobe when it saw credit_ok
	a_no_issue_at_zero: assert property (@(posedge clk) disable iff (!rst_b)
		out_valid |-> credits != '0);

	// The bus never returns more credits than it handed out
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_b)
		credits <= INITIAL_CREDITS);

endmodule

/* fill_buffer.sv */
// Inbound beat filter and FIFO feeding line fills to the cache core
`timescale 1ns/1ps

module fill_buffer import dcache_pkg::*; (
	input  logic    clk,
	input  logic    rst_b,
	input  logic    in_valid,
	input  dev_id_t in_did,
	input  dev_id_t in_subdid,
	input  beat_t   in_data,
	fill_if.buffer  fill
);

	logic                       beat_hit_q; // Registered beat is addressed to us
	beat_t                      beat_q;
	beat_t                      mem [FILL_DEPTH];
	beat_idx_t                  wr_ptr;
	beat_idx_t                  rd_ptr;
	logic [$clog2(FILL_DEPTH):0] count;
	logic                       push;

	// Input register stage, foreign ids never reach the FIFO
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			beat_hit_q <= 1'b0;
		end else begin
			beat_hit_q <= in_valid && (in_did == DID_CPU) && (in_subdid == SUBDID_DCACHE);
		end
	end

	always_ff @(posedge clk) begin
		beat_q <= in_data;
		if (push)
			mem[wr_ptr] <= beat_q;
	end

	assign push = beat_hit_q && !fill.clear;

	// Pointers wrap on their own since the depth matches the pointer range
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (fill.clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (fill.pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + push - fill.pop;
		end
	end

	assign fill.beat_valid = (count != '0);
	assign fill.beat_data = mem[rd_ptr];

	// A single line read can never return more beats than the buffer holds
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_b)
		beat_hit_q |-> count != ($clog2(FILL_DEPTH) + 1)'(FILL_DEPTH));

endmodule

/* dcache_core.sv */
// Tag, valid and data arrays, hit test, miss FSM, write-through and read pipeline
`timescale 1ns/1ps

module dcache_core import dcache_pkg::*; (
	input  logic    clk,
	input  logic    rst_b,
	input  addr_t   cpu_addr,
	input  logic    cpu_rd_req,
	input  logic    cpu_wr_req,
	input  word_t   cpu_wr_data,
	output logic    cpu_wait,
	output word_t   cpu_rd_data,
	bus_req_if.core req,
	fill_if.core    fill
);

	logic [NUM_LINES-1:0] line_valid;
	tag_t                 line_tag [NUM_LINES];
	beat_t                line_data [NUM_LINES*BEATS_PER_LINE]; // Indexed by {line, beat}

	tag_t        req_tag;
	index_t      req_idx;
	beat_idx_t   req_beat;
	beat_t       hit_beat;
	logic        hit;
	logic        rd_accept;
	logic        wr_accept;
	logic        miss_issue;
	logic        last_beat;
	miss_state_t state;
	tag_t        fill_tag;
	index_t      fill_idx;
	beat_idx_t   fill_pos;

	assign req_tag = cpu_addr[31:10];
	assign req_idx = cpu_addr[9:6];
	assign req_beat = cpu_addr[5:3];
	assign hit = line_valid[req_idx] && (line_tag[req_idx] == req_tag);
	assign hit_beat = line_data[{req_idx, req_beat}];

	// Stall reads until they hit and writes until a credit is free
	always_comb begin
		cpu_wait = 1'b0;
		if (cpu_rd_req && (!hit || state != MISS_IDLE))
			cpu_wait = 1'b1;
		if (cpu_wr_req && (state != MISS_IDLE || !req.credit_ok))
			cpu_wait = 1'b1;
	end

	assign rd_accept = cpu_rd_req && !cpu_wait;
	assign wr_accept = cpu_wr_req && !cpu_wait;
	assign miss_issue = (state == MISS_REQUEST) && req.credit_ok;
	assign last_beat = fill.pop && (fill_pos == beat_idx_t'(BEATS_PER_LINE - 1));

	assign fill.pop = (state == MISS_FILL) && fill.beat_valid;
	assign fill.clear = miss_issue; // Drop anything left from an earlier fill

	// The CPU holds its address during a miss, so the line read uses it directly
	assign req.req = miss_issue || wr_accept;
	assign req.is_write = wr_accept;
	assign req.addr = cpu_addr;
	assign req.wdata = cpu_wr_data;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state <= MISS_IDLE;
			line_valid <= '0;
			fill_tag <= '0;
			fill_idx <= '0;
			fill_pos <= '0;
		end else begin
			case (state)
			MISS_IDLE: begin
				if (cpu_rd_req && !hit)
					state <= MISS_REQUEST;
			end
			MISS_REQUEST: begin
				if (req.credit_ok) begin
					line_valid[req_idx] <= 1'b0; // Old contents are being replaced
					fill_tag <= req_tag;
					fill_idx <= req_idx;
					fill_pos <= '0;
					state <= MISS_FILL;
				end
			end
			MISS_FILL: begin
				if (fill.pop)
					fill_pos <= fill_pos + 1'b1;
				if (last_beat) begin
					line_valid[fill_idx] <= 1'b1;
					state <= MISS_IDLE;
				end
			end
			default: state <= MISS_IDLE;
			endcase
		end
	end

	// Fills and write hits never overlap since writes stall outside idle
	always_ff @(posedge clk) begin
		if (fill.pop)
			line_data[{fill_idx, fill_pos}] <= fill.beat_data;
		if (wr_accept && hit) begin
			if (cpu_addr[2])
				line_data[{req_idx, req_beat}][63:32] <= cpu_wr_data;
			else
				line_data[{req_idx, req_beat}][31:0] <= cpu_wr_data;
		end
		if (last_beat)
			line_tag[fill_idx] <= fill_tag;
		if (rd_accept)
			cpu_rd_data <= cpu_addr[2] ? hit_beat[63:32] : hit_beat[31:0];
	end

	// Beats only sit in the buffer while a line fill drains them
	a_no_stray_beats: assert property (@(posedge clk) disable iff (!rst_b)
		fill.beat_valid |-> state == MISS_FILL);

	// The line read and the invalidate both use the address the CPU holds
	a_addr_held: assert property (@(posedge clk) disable iff (!rst_b)
		(cpu_rd_req || cpu_wr_req) && cpu_wait |=> $stable(cpu_addr));

endmodule

/* dcache_top.sv */
// Data cache top level with plain CPU and bus ports
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
	input  logic      clk,
	input  logic      rst_b,
	input  addr_t     cpu_addr,
	input  logic      cpu_rd_req,
	input  logic      cpu_wr_req,
	input  word_t     cpu_wr_data,
	output logic      cpu_wait,
	output word_t     cpu_rd_data,
	output logic      bus_out_valid,
	output bus_mode_t bus_out_mode,
	output dev_id_t   bus_out_did,
	output dev_id_t   bus_out_subdid,
	output addr_t     bus_out_addr,
	output bus_len_t  bus_out_len,
	output beat_t     bus_out_data,
	output mask_t     bus_out_mask,
	input  logic      bus_out_credit,
	input  logic      bus_in_valid,
	input  dev_id_t   bus_in_did,
	input  dev_id_t   bus_in_subdid,
	input  beat_t     bus_in_data
);

	bus_req_if req_bus ();
	fill_if    fill_bus ();

	bus_req_issuer bus_req_issuer_inst (
		.clk        (clk),
		.rst_b      (rst_b),
		.bus        (req_bus),
		.out_valid  (bus_out_valid),
		.out_mode   (bus_out_mode),
		.out_did    (bus_out_did),
		.out_subdid (bus_out_subdid),
		.out_addr   (bus_out_addr),
		.out_len    (bus_out_len),
		.out_data   (bus_out_data),
		.out_mask   (bus_out_mask),
		.out_credit (bus_out_credit)
	);

	fill_buffer fill_buffer_inst (
		.clk       (clk),
		.rst_b     (rst_b),
		.in_valid  (bus_in_valid),
		.in_did    (bus_in_did),
		.in_subdid (bus_in_subdid),
		.in_data   (bus_in_data),
		.fill      (fill_bus)
	);

	dcache_core dcache_core_inst (
		.clk         (clk),
		.rst_b       (rst_b),
		.cpu_addr    (cpu_addr),
		.cpu_rd_req  (cpu_rd_req),
		.cpu_wr_req  (cpu_wr_req),
		.cpu_wr_data (cpu_wr_data),
		.cpu_wait    (cpu_wait),
		.cpu_rd_data (cpu_rd_data),
		.req         (req_bus),
		.fill        (fill_bus)
	);

endmodule

/* tb_dcache.sv */
// Data cache testbench with bus memory model, shadow memory, reference function and watchdog
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

	localparam int NUM_RANDOM = 300;
	localparam int NUM_OPS = NUM_RANDOM + 30; // Random mix plus the directed operations

	logic clk = 1'b0;
	logic rst_b, cpu_rd_req, cpu_wr_req, cpu_wait, bus_out_valid, bus_out_credit, bus_in_valid;
	addr_t cpu_addr, bus_out_addr;
	word_t cpu_wr_data, cpu_rd_data;
	bus_mode_t bus_out_mode;
	dev_id_t bus_out_did, bus_out_subdid, bus_in_did, bus_in_subdid;
	bus_len_t bus_out_len;
	beat_t bus_out_data, bus_in_data;
	mask_t bus_out_mask;

	word_t shadow [addr_t];    // Expected contents, updated by the stimulus
	word_t model_mem [addr_t]; // Device memory, updated by bus writes
	addr_t line_q [$];         // Line reads waiting to be served
	int credit_due [$];        // Cycle at which each credit may return
	int errors = 0, n_reqs = 0, n_line_reads = 0, n_bus_writes = 0, cycle = 0, n_writes = 0;
	logic hold_credits;
	addr_t cur_addr;
	word_t cur_data;

	dcache_top dcache_top_inst (.*);

	always #2 clk = ~clk;

	// Background pattern for words never written
	function automatic word_t mem_word(addr_t a);
		return {a[15:0], a[31:16]} ^ (a * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
	endfunction

	function automatic word_t ref_word(addr_t a);
		return shadow.exists(a) ? shadow[a] : mem_word(a);
	endfunction

	function automatic word_t model_word(addr_t a);
		return model_mem.exists(a) ? model_mem[a] : mem_word(a);
	endfunction

	function automatic void store_beat(addr_t base, beat_t data, mask_t mask);
		addr_t wa;
		word_t w;
		int b;
		for (b = 0; b < 8; b++) begin
			if (mask[b]) begin
				wa = base + addr_t'((b / 4) * 4);
				w = model_word(wa);
				w[(b % 4) * 8 +: 8] = data[b * 8 +: 8];
				model_mem[wa] = w;
			end
		end
	endfunction

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(string name, addr_t got, addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_mask(string name, mask_t got, mask_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_len(string name, bus_len_t got, bus_len_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_id(string name, dev_id_t got, dev_id_t exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic expect_line_reads(int mark, int n);
		if (n_line_reads - mark != n) begin
			errors++;
			$display("Expected %0d line reads but saw %0d", n, n_line_reads - mark);
		end
	endtask

	task automatic do_read(addr_t a);
		@(negedge clk);
		cur_addr = a;
		cpu_addr = a;
		cpu_rd_req = 1'b1;
		do @(posedge clk); while (cpu_wait);
		@(negedge clk);
		cpu_rd_req = 1'b0;
		check_word("cpu_rd_data", cpu_rd_data, ref_word(a));
	endtask

	task automatic do_write(addr_t a, word_t d);
		@(negedge clk);
		cur_addr = a;
		cur_data = d;
		cpu_addr = a;
		cpu_wr_data = d;
		cpu_wr_req = 1'b1;
		do @(posedge clk); while (cpu_wait);
		shadow[a] = d;
		n_writes++;
		@(negedge clk);
		cpu_wr_req = 1'b0;
	endtask

	// Bus request monitor, outputs are settled before the rising edge
	always @(posedge clk) begin
		if (rst_b && bus_out_valid) begin
			n_reqs++;
			credit_due.push_back(cycle + $urandom_range(1, 6));
			check_id("bus_out_did", bus_out_did, DID_CPU);
			check_id("bus_out_subdid", bus_out_subdid, SUBDID_DCACHE);
			if (bus_out_mode == MODE_READ) begin
				n_line_reads++;
				check_addr("bus_out_addr", bus_out_addr, {cur_addr[31:6], 6'b000000});
				check_len("bus_out_len", bus_out_len, LINE_READ_LEN);
				line_q.push_back(bus_out_addr);
			end else if (bus_out_mode == MODE_WRITE) begin
				n_bus_writes++;
				check_addr("bus_out_addr", bus_out_addr, {cur_addr[31:3], 3'b000});
				check_len("bus_out_len", bus_out_len, WORD_WRITE_LEN);
				check_mask("bus_out_mask", bus_out_mask, cur_addr[2] ? 8'hF0 : 8'h0F);
				check_word("bus_out_data[63:32]", bus_out_data[63:32], cur_data);
				check_word("bus_out_data[31:0]", bus_out_data[31:0], cur_data);
				store_beat(bus_out_addr, bus_out_data, bus_out_mask);
			end else begin
				errors++;
				$display("Bus request with unknown mode %0d", bus_out_mode);
			end
		end
	end

	// One credit per cycle at most, held back while the switch is set
	always @(negedge clk) begin
		cycle++;
		bus_out_credit = 1'b0;
		if (!hold_credits && credit_due.size() != 0 && credit_due[0] <= cycle) begin
			void'(credit_due.pop_front());
			bus_out_credit = 1'b1;
		end
	end

	initial begin : line_server
		addr_t base;
		int beat;
		forever begin
			@(negedge clk);
			if (line_q.size() != 0) begin
				base = line_q.pop_front();
				repeat ($urandom_range(2, 10) - 1) @(negedge clk);
				beat = 0;
				while (beat < BEATS_PER_LINE) begin
					if ($urandom_range(0, 3) == 0) begin // Beat for some other device
						if ($urandom_range(0, 1) == 1) begin
							bus_in_did = DID_CPU;
							bus_in_subdid = dev_id_t'($urandom_range(3, 15)); // Other CPU unit
						end else begin
							bus_in_did = dev_id_t'($urandom_range(2, 15));
							bus_in_subdid = SUBDID_DCACHE;
						end
						bus_in_data = {$urandom, $urandom};
					end else begin
						bus_in_did = DID_CPU;
						bus_in_subdid = SUBDID_DCACHE;
						bus_in_data = {model_word(base + addr_t'(beat * 8 + 4)),
							model_word(base + addr_t'(beat * 8))};
						beat++;
					end
					bus_in_valid = 1'b1;
					@(negedge clk);
				end
				bus_in_valid = 1'b0;
			end
		end
	end

	initial begin : watchdog
		repeat (NUM_OPS * 200 + 1000) @(posedge clk);
		$display("Timeout with %0d errors after %0d bus requests", errors, n_reqs);
		$display("Checks failed");
		$finish;
	end

	initial begin : stimulus
		addr_t a;
		int mark;
		int i;
		void'($urandom(32'h52750c01));
		rst_b = 1'b0;
		cpu_addr = '0;
		cpu_rd_req = 1'b0;
		cpu_wr_req = 1'b0;
		cpu_wr_data = '0;
		bus_out_credit = 1'b0;
		bus_in_valid = 1'b0;
		bus_in_did = '0;
		bus_in_subdid = '0;
		bus_in_data = '0;
		hold_credits = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_b = 1'b1;
		if (bus_out_valid !== 1'b0 || cpu_wait !== 1'b0) begin
			errors++;
			$display("[ERROR] bus_out_valid %h cpu_wait %h after reset, expected 0",
				bus_out_valid, cpu_wait);
		end
		mark = n_line_reads; // Cold read, then hits in the same line
		do_read(32'h0000_1040);
		do_read(32'h0000_1044);
		do_read(32'h0000_107C);
		expect_line_reads(mark, 1);
		mark = n_line_reads; // Write-through to a resident and a non-resident line
		do_write(32'h0000_1048, 32'hCAFE_0001);
		do_read(32'h0000_1048);
		do_write(32'h0000_2084, 32'hBEEF_0002);
		do_read(32'h0000_2084);
		expect_line_reads(mark, 1);
		mark = n_line_reads; // Two tags on one index evict each other
		do_read(32'h0000_1440);
		do_read(32'h0000_1040);
		do_read(32'h0000_1440);
		expect_line_reads(mark, 3);
		hold_credits = 1'b1;
		mark = n_reqs;
		fork
			for (i = 0; i < 6; i++)
				do_write(32'h0000_3000 + addr_t'(i * 4), 32'hD00D_0000 + word_t'(i));
		join_none
		repeat (40) @(posedge clk);
		if (n_reqs - mark > INITIAL_CREDITS || !cpu_wait) begin
			errors++;
			$display("Requests issued or CPU released while credits were held");
		end
		hold_credits = 1'b0;
		wait fork;
		for (i = 0; i < 6; i++)
			do_read(32'h0000_3000 + addr_t'(i * 4));
		repeat (NUM_RANDOM) begin
			a = addr_t'($urandom_range(0, 1023)) << 2;
			if ($urandom_range(0, 1) == 1)
				do_write(a, $urandom);
			else
				do_read(a);
		end
		if (n_bus_writes != n_writes) begin
			errors++;
			$display("Saw %0d bus writes for %0d CPU writes", n_bus_writes, n_writes);
		end
		$display("Errors %0d, bus requests %0d, line reads %0d, bus writes %0d",
			errors, n_reqs, n_line_reads, n_bus_writes);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* list.f */
dcache_pkg.sv
dcache_ifs.sv
bus_req_issuer.sv
fill_buffer.sv
dcache_core.sv
dcache_top.sv
tb_dcache.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_dcache
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "Checks failed" $(LOG)
	@grep -q "All checks passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: all build run lint clean
